// File: common/shift_pkg.sv
// *************************************************
// Data-path widths, shift opcodes and the request
// and response structs of the shift unit
// *************************************************

`default_nettype none

package shift_pkg;

	// Operand and result width
	localparam int unsigned DATA_W = 32;
	// Shift amount width, log2 of DATA_W
	localparam int unsigned AMT_W = 5;

	// *************************************************
	// Opcodes
	// *************************************************

	typedef enum logic [2:0]
	{
		OP_SLL = 3'd0,  // logical left
		OP_SRL = 3'd1,  // logical right
		OP_SRA = 3'd2,  // arithmetic right, sign fill
		OP_ROL = 3'd3,  // rotate left
		OP_ROR = 3'd4   // rotate right
	} shift_op_e;

	// *************************************************
	// Request and response
	// *************************************************

	// One-cycle strobe, no back-pressure
	typedef struct packed {
		logic               valid;
		shift_op_e          op;
		logic [AMT_W-1:0]   amount;
		logic [DATA_W-1:0]  data;
	} shift_req_t;

	// Valid for exactly one cycle, two cycles after the request
	typedef struct packed {
		logic               valid;
		logic [DATA_W-1:0]  data;
	} shift_resp_t;

endpackage

`default_nettype wire

// File: common/cfg_pkg.sv
// *************************************************
// Configuration addresses, control register layout
// and the register read and write structs
// *************************************************

`default_nettype none

package cfg_pkg;

	// Register data and address widths
	localparam int unsigned CFG_DATA_W = 32;
	localparam int unsigned CFG_ADDR_W = 2;

	// Register map
	typedef enum logic [CFG_ADDR_W-1:0]
	{
		CFG_CTRL     = 2'd0,  // read and write
		CFG_OPS_DONE = 2'd1   // read only, completed operations
	} cfg_addr_e;

	// Control register, fill_ones sits in bit 0
	typedef struct packed {
		logic [CFG_DATA_W-2:0] reserved;
		logic                  fill_ones;
	} cfg_ctrl_t;

	// Write strobe
	typedef struct packed {
		logic                  valid;
		cfg_addr_e             addr;
		logic [CFG_DATA_W-1:0] data;
	} cfg_wr_t;

	// Read strobe and its answer one cycle later
	typedef struct packed {
		logic      valid;
		cfg_addr_e addr;
	} cfg_rd_req_t;

	typedef struct packed {
		logic                  valid;
		logic [CFG_DATA_W-1:0] data;
	} cfg_rd_resp_t;

endpackage

`default_nettype wire

// File: shifter/shift_stage.sv
// *************************************************
// Fixed-distance shift stage, combinational
// *************************************************

`default_nettype none

module shift_stage
#(
	// Shift distance of this stage, 1 to DATA_W-1
	parameter int unsigned DIST = 1
)
(
	input  logic [shift_pkg::DATA_W-1:0] data_in,
	input  logic                         active,
	input  logic                         left,
	input  logic                         rotate,
	input  logic                         fill_low,
	input  logic                         fill_high,
	output logic [shift_pkg::DATA_W-1:0] data_out
);

	// Two copies back to back
	// Any rotation by DIST is a window of this vector
	logic [2*shift_pkg::DATA_W-1:0] doubled;

	assign doubled = {data_in, data_in};

	// *************************************************
	// Shift select and fill
	// *************************************************

	always_comb
	begin
		// Inactive stage passes data through
		data_out = data_in;
		if (active)
		begin
			if (left)
			begin
				// Window ending DIST bits below the top gives rotate left
				data_out = doubled[2*shift_pkg::DATA_W-1-DIST -: shift_pkg::DATA_W];
				// Plain shift overwrites the wrapped bits at the bottom
				if (!rotate)
				begin
					data_out[DIST-1:0] = {DIST{fill_low}};
				end
			end
			else
			begin
				// Window starting DIST bits up gives rotate right
				data_out = doubled[shift_pkg::DATA_W-1+DIST -: shift_pkg::DATA_W];
				// Plain shift overwrites the wrapped bits at the top
				if (!rotate)
				begin
					data_out[shift_pkg::DATA_W-1 -: DIST] = {DIST{fill_high}};
				end
			end
		end
	end

endmodule

`default_nettype wire

// File: shifter/barrel_shifter.sv
// *************************************************
// Two-stage pipelined barrel shifter, five stages
// of 1, 2, 4, 8 and 16 bits with opcode decode
// *************************************************

`default_nettype none

module barrel_shifter
(
	input  logic                   clk,
	input  logic                   rst,
	input  shift_pkg::shift_req_t  req,
	input  cfg_pkg::cfg_ctrl_t     ctrl,
	output shift_pkg::shift_resp_t resp,
	output logic                   op_done
);

	// Contents of the middle register
	// Decoded controls travel with the partly shifted data
	typedef struct packed {
		logic                            valid;
		logic                            left;
		logic                            rotate;
		logic                            fill_low;
		logic                            fill_high;
		logic [shift_pkg::AMT_W-4:0]     amt_hi;
		logic [shift_pkg::DATA_W-1:0]    data;
	} mid_stage_t;

	mid_stage_t mid_d;
	mid_stage_t mid_q;

	// Stage chains, index 0 is the chain input
	logic [shift_pkg::DATA_W-1:0] front_data [0:3];
	logic [shift_pkg::DATA_W-1:0] back_data  [0:2];

	// *************************************************
	// Opcode decode
	// *************************************************

	always_comb
	begin
		mid_d.left      = 1'b0;
		mid_d.rotate    = 1'b0;
		mid_d.fill_low  = 1'b0;
		mid_d.fill_high = 1'b0;
		case (req.op)
			shift_pkg::OP_SLL:
			begin
				mid_d.left     = 1'b1;
				mid_d.fill_low = ctrl.fill_ones;
			end
			shift_pkg::OP_SRL:
			begin
				mid_d.fill_high = ctrl.fill_ones;
			end
			// Sign bit of the original operand fills every stage
			shift_pkg::OP_SRA:
			begin
				mid_d.fill_high = req.data[shift_pkg::DATA_W-1];
			end
			shift_pkg::OP_ROL:
			begin
				mid_d.left   = 1'b1;
				mid_d.rotate = 1'b1;
			end
			shift_pkg::OP_ROR:
			begin
				mid_d.rotate = 1'b1;
			end
			// Unused codes act as a zero-fill left shift
			default:
			begin
				mid_d.left = 1'b1;
			end
		endcase
		mid_d.valid  = req.valid;
		mid_d.amt_hi = req.amount[shift_pkg::AMT_W-1:3];
		mid_d.data   = front_data[3];
	end

	// *************************************************
	// Front stages, 1, 2 and 4 bits
	// *************************************************

	assign front_data[0] = req.data;

	for (genvar i = 0; i < 3; i++)
	begin : g_front
		shift_stage #(.DIST(1 << i)) shift_stage_i
		(
			.data_in   (front_data[i]),
			.active    (req.amount[i]),
			.left      (mid_d.left),
			.rotate    (mid_d.rotate),
			.fill_low  (mid_d.fill_low),
			.fill_high (mid_d.fill_high),
			.data_out  (front_data[i+1])
		);
	end

	// Middle register, only valid is cleared
	always_ff @(posedge clk)
	begin
		mid_q <= mid_d;
		if (rst)
		begin
			mid_q.valid <= 1'b0;
		end
	end

	// *************************************************
	// Back stages, 8 and 16 bits
	// *************************************************

	assign back_data[0] = mid_q.data;

	for (genvar i = 0; i < 2; i++)
	begin : g_back
		shift_stage #(.DIST(8 << i)) shift_stage_i
		(
			.data_in   (back_data[i]),
			.active    (mid_q.amt_hi[i]),
			.left      (mid_q.left),
			.rotate    (mid_q.rotate),
			.fill_low  (mid_q.fill_low),
			.fill_high (mid_q.fill_high),
			.data_out  (back_data[i+1])
		);
	end

	// Output register
	always_ff @(posedge clk)
	begin
		resp.data <= back_data[2];
		if (rst)
		begin
			resp.valid <= 1'b0;
		end
		else
		begin
			resp.valid <= mid_q.valid;
		end
	end

	// One strobe per completed operation
	assign op_done = resp.valid;

endmodule

`default_nettype wire

// File: design/shift_cfg_regs.sv
// *************************************************
// Control register, completed-operation counter
// and registered read port
// *************************************************

`default_nettype none

module shift_cfg_regs
(
	input  logic                  clk,
	input  logic                  rst,
	input  cfg_pkg::cfg_wr_t      wr,
	input  cfg_pkg::cfg_rd_req_t  rd_req,
	output cfg_pkg::cfg_rd_resp_t rd_resp,
	output cfg_pkg::cfg_ctrl_t    ctrl,
	input  logic                  op_done
);

	// Only stored control bit
	logic fill_ones_q;
	// Completed operations, wraps at 2^32
	logic [cfg_pkg::CFG_DATA_W-1:0] ops_done_q;
	// Read mux output
	logic [cfg_pkg::CFG_DATA_W-1:0] rd_data;

	// *************************************************
	// Control register
	// *************************************************

	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			fill_ones_q <= 1'b0;
		end
		else if (wr.valid && (wr.addr == cfg_pkg::CFG_CTRL))
		begin
			fill_ones_q <= wr.data[0];
		end
	end

	// Reserved bits are tied to zero
	assign ctrl.reserved  = '0;
	assign ctrl.fill_ones = fill_ones_q;

	// *************************************************
	// Operation counter
	// *************************************************

	// Writes to CFG_OPS_DONE are ignored
	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			ops_done_q <= '0;
		end
		else if (op_done)
		begin
			ops_done_q <= ops_done_q + 1'b1;
		end
	end

	// *************************************************
	// Read port
	// *************************************************

	// Current register values, so a same-cycle write reads old data
	always_comb
	begin
		case (rd_req.addr)
			cfg_pkg::CFG_CTRL:     rd_data = ctrl;
			cfg_pkg::CFG_OPS_DONE: rd_data = ops_done_q;
			default:               rd_data = '0;
		endcase
	end

	// Answer one cycle after the strobe
	always_ff @(posedge clk)
	begin
		rd_resp.data <= rd_data;
		if (rst)
		begin
			rd_resp.valid <= 1'b0;
		end
		else
		begin
			rd_resp.valid <= rd_req.valid;
		end
	end

endmodule

`default_nettype wire

// File: design/shift_unit_top.sv
// *************************************************
// Shift unit top, barrel shifter with its
// configuration registers
// *************************************************

`default_nettype none

module shift_unit_top
(
	input  logic                   clk,
	input  logic                   rst,
	input  shift_pkg::shift_req_t  shift_req,
	output shift_pkg::shift_resp_t shift_resp,
	input  cfg_pkg::cfg_wr_t       cfg_wr,
	input  cfg_pkg::cfg_rd_req_t   cfg_rd_req,
	output cfg_pkg::cfg_rd_resp_t  cfg_rd_resp
);

	// Control bits steering the shifter
	cfg_pkg::cfg_ctrl_t ctrl;
	// Completion strobe into the counter
	logic op_done;

	// *************************************************
	// Shift data path
	// *************************************************

	barrel_shifter barrel_shifter_i
	(
		.clk     (clk),
		.rst     (rst),
		.req     (shift_req),
		.ctrl    (ctrl),
		.resp    (shift_resp),
		.op_done (op_done)
	);

	// *************************************************
	// Configuration registers
	// *************************************************

	shift_cfg_regs shift_cfg_regs_i
	(
		.clk     (clk),
		.rst     (rst),
		.wr      (cfg_wr),
		.rd_req  (cfg_rd_req),
		.rd_resp (cfg_rd_resp),
		.ctrl    (ctrl),
		.op_done (op_done)
	);

endmodule

`default_nettype wire

// File: bench/tb_clk_gen.sv
// *************************************************
// Testbench clock, 4 ns period
// *************************************************

`default_nettype none

module tb_clk_gen
(
	output logic clk
);

	timeunit 1ns;
	timeprecision 1ps;

	// Half of the 4 ns period
	localparam realtime HALF_PERIOD = 2ns;

	initial
	begin
		clk = 1'b0;
		forever
		begin
			#HALF_PERIOD clk = ~clk;
		end
	end

endmodule

`default_nettype wire

// File: bench/shift_unit_chk.sv
// *************************************************
// Assertions on response timing and reset state
// *************************************************

`default_nettype none

module shift_unit_chk
(
	input logic clk,
	input logic rst,
	input logic req_valid,
	input logic resp_valid,
	input logic rd_req_valid,
	input logic rd_resp_valid
);

	timeunit 1ns;
	timeprecision 1ps;

	// Shift response two edges after each request
	resp_latency_a: assert property (@(posedge clk) disable iff (rst)
		req_valid |-> ##2 resp_valid)
		else $error("shift response missing two cycles after a request");

	// No response without a request two edges earlier
	resp_origin_a: assert property (@(posedge clk) disable iff (rst)
		resp_valid |-> $past(req_valid, 2))
		else $error("shift response without a matching request");

	// Both valids held low while in reset
	reset_quiet_a: assert property (@(posedge clk)
		rst && $past(rst) |-> !resp_valid && !rd_resp_valid)
		else $error("valid output high during reset");

	// Read answer one edge after the strobe, and only then
	rd_latency_a: assert property (@(posedge clk) disable iff (rst)
		rd_req_valid |=> rd_resp_valid)
		else $error("read response missing one cycle after a read strobe");

	rd_origin_a: assert property (@(posedge clk) disable iff (rst)
		rd_resp_valid |-> $past(rd_req_valid))
		else $error("read response without a read strobe");

endmodule

bind shift_unit_top shift_unit_chk shift_unit_chk_i
(
	.clk           (clk),
	.rst           (rst),
	.req_valid     (shift_req.valid),
	.resp_valid    (shift_resp.valid),
	.rd_req_valid  (cfg_rd_req.valid),
	.rd_resp_valid (cfg_rd_resp.valid)
);

`default_nettype wire

// File: bench/shift_unit_tb.sv
// *************************************************
// Directed tests of the shift unit with reference
// model, LFSR stimulus and a single check task
// *************************************************

`default_nettype none

module shift_unit_tb;

	timeunit 1ns;
	timeprecision 1ps;

	// Cycles allowed for any awaited response
	localparam int unsigned TIMEOUT = 20;
	localparam int unsigned STREAM_LEN = 200;

	logic                   clk;
	logic                   rst;
	shift_pkg::shift_req_t  shift_req;
	shift_pkg::shift_resp_t shift_resp;
	cfg_pkg::cfg_wr_t       cfg_wr;
	cfg_pkg::cfg_rd_req_t   cfg_rd_req;
	cfg_pkg::cfg_rd_resp_t  cfg_rd_resp;

	logic [15:0] lfsr_state;
	// Requests sent since reset
	logic [31:0] issued;
	// Model of the fill_ones bit as last written
	logic        fill_ones_model;
	logic        run_ended;
	logic [31:0] expected_q [$];

	tb_clk_gen tb_clk_gen_i (.clk(clk));

	shift_unit_top shift_unit_top_i
	(
		.clk         (clk),
		.rst         (rst),
		.shift_req   (shift_req),
		.shift_resp  (shift_resp),
		.cfg_wr      (cfg_wr),
		.cfg_rd_req  (cfg_rd_req),
		.cfg_rd_resp (cfg_rd_resp)
	);

	// *************************************************
	// Helpers
	// *************************************************

	// Drive and sample point, 1 ns after the rising edge
	task automatic next_cycle();
		@(posedge clk);
		#1;
	endtask

	task automatic fail_run(input string reason);
		$display("%s", reason);
		run_ended = 1'b1;
		$display("*** TEST FAILED ***");
		$fatal(1, "stopping at first error");
	endtask

	task automatic check_value(input string test_name, input logic [31:0] expected,
		input logic [31:0] actual);
		if (expected !== actual)
		begin
			fail_run($sformatf("Fail %s: expected %h, actual %h", test_name, expected, actual));
		end
	endtask

	// x^16 + x^14 + x^13 + x^11 + 1
	function automatic logic [15:0] lfsr_next(input logic [15:0] state);
		return {state[14:0], state[15] ^ state[13] ^ state[12] ^ state[10]};
	endfunction

	// One LFSR step per bit taken
	task automatic random_value(input int unsigned nbits, output logic [31:0] value);
		value = '0;
		for (int unsigned i = 0; i < nbits; i++)
		begin
			value = {value[30:0], lfsr_state[15]};
			lfsr_state = lfsr_next(lfsr_state);
		end
	endtask

	// Reference model of the five operations
	function automatic logic [31:0] expected_shift(input shift_pkg::shift_op_e op,
		input logic [4:0] amount, input logic [31:0] data, input logic fill_ones);
		logic [31:0] ones;
		logic [63:0] doubled;
		logic [31:0] result;
		ones = '1;
		doubled = {data, data} << amount;
		case (op)
			shift_pkg::OP_SLL: result = (data << amount) | (fill_ones ? ~(ones << amount) : '0);
			shift_pkg::OP_SRL: result = (data >> amount) | (fill_ones ? ~(ones >> amount) : '0);
			shift_pkg::OP_SRA: result = $unsigned($signed(data) >>> amount);
			// Top half of the doubled word after a left shift
			shift_pkg::OP_ROL: result = doubled[63:32];
			shift_pkg::OP_ROR: result = 32'(({data, data} >> amount));
			default:           result = data << amount;
		endcase
		return result;
	endfunction

	task automatic drive_shift(input shift_pkg::shift_op_e op, input logic [4:0] amount,
		input logic [31:0] data);
		shift_req.valid  = 1'b1;
		shift_req.op     = op;
		shift_req.amount = amount;
		shift_req.data   = data;
		issued = issued + 1;
	endtask

	// Single request, waits for its response and checks data and latency
	task automatic run_shift(input string test_name, input shift_pkg::shift_op_e op,
		input logic [4:0] amount, input logic [31:0] data);
		logic [31:0] expected;
		logic [31:0] latency;
		expected = expected_shift(op, amount, data, fill_ones_model);
		drive_shift(op, amount, data);
		next_cycle();
		shift_req.valid = 1'b0;
		// The edge that samples the request counts as the first cycle
		latency = 1;
		while (!shift_resp.valid && latency < TIMEOUT)
		begin
			next_cycle();
			latency = latency + 1;
		end
		if (!shift_resp.valid)
		begin
			fail_run($sformatf("Shift response for %s never arrived", test_name));
		end
		check_value({test_name, " latency"}, 32'd2, latency);
		check_value(test_name, expected, shift_resp.data);
	endtask

	task automatic write_reg(input cfg_pkg::cfg_addr_e addr, input logic [31:0] data);
		cfg_wr.valid = 1'b1;
		cfg_wr.addr  = addr;
		cfg_wr.data  = data;
		if (addr == cfg_pkg::CFG_CTRL)
		begin
			fill_ones_model = data[0];
		end
		next_cycle();
		cfg_wr.valid = 1'b0;
	endtask

	task automatic read_reg(input string test_name, input cfg_pkg::cfg_addr_e addr,
		output logic [31:0] data);
		logic [31:0] latency;
		cfg_rd_req.valid = 1'b1;
		cfg_rd_req.addr  = addr;
		next_cycle();
		cfg_rd_req.valid = 1'b0;
		// The edge that samples the strobe counts as the first cycle
		latency = 1;
		while (!cfg_rd_resp.valid && latency < TIMEOUT)
		begin
			next_cycle();
			latency = latency + 1;
		end
		if (!cfg_rd_resp.valid)
		begin
			fail_run($sformatf("Register read for %s never answered", test_name));
		end
		check_value({test_name, " read latency"}, 32'd1, latency);
		data = cfg_rd_resp.data;
	endtask

	task automatic check_read(input string test_name, input cfg_pkg::cfg_addr_e addr,
		input logic [31:0] expected);
		logic [31:0] data;
		read_reg(test_name, addr, data);
		check_value(test_name, expected, data);
	endtask

	// *************************************************
	// Tests
	// *************************************************

	task automatic test_reset_state();
		check_read("reset ctrl", cfg_pkg::CFG_CTRL, 32'd0);
		check_read("reset ops_done", cfg_pkg::CFG_OPS_DONE, 32'd0);
	endtask

	task automatic test_directed_shifts();
		logic [4:0] amounts [0:5];
		logic [31:0] operands [0:2];
		shift_pkg::shift_op_e op;
		amounts = '{5'd0, 5'd1, 5'd4, 5'd5, 5'd16, 5'd31};
		// Two negative operands for the sign fill
		operands = '{32'h8000_0001, 32'h1234_5678, 32'hF0F0_0F0F};
		for (int o = 0; o < 5; o++)
		begin
			op = shift_pkg::shift_op_e'(3'(o));
			foreach (amounts[a])
			begin
				foreach (operands[d])
				begin
					run_shift($sformatf("directed %s amt %0d op %h", op.name(), amounts[a],
						operands[d]), op, amounts[a], operands[d]);
				end
			end
		end
	endtask

	task automatic test_fill_control();
		logic [4:0] amounts [0:2];
		shift_pkg::shift_op_e op;
		amounts = '{5'd3, 5'd12, 5'd31};
		write_reg(cfg_pkg::CFG_CTRL, 32'd1);
		check_read("fill readback", cfg_pkg::CFG_CTRL, 32'd1);
		// Ones fill only in logical shifts
		for (int o = 0; o < 5; o++)
		begin
			op = shift_pkg::shift_op_e'(3'(o));
			foreach (amounts[a])
			begin
				run_shift($sformatf("fill one %s amt %0d", op.name(), amounts[a]), op,
					amounts[a], 32'h0F0F_1234);
				run_shift($sformatf("fill one %s amt %0d neg", op.name(), amounts[a]), op,
					amounts[a], 32'hC000_0081);
			end
		end
		write_reg(cfg_pkg::CFG_CTRL, 32'd0);
		check_read("fill cleared", cfg_pkg::CFG_CTRL, 32'd0);
		run_shift("fill zero sll", shift_pkg::OP_SLL, 5'd8, 32'hFFFF_FFFF);
		run_shift("fill zero srl", shift_pkg::OP_SRL, 5'd8, 32'hFFFF_FFFF);
	endtask

	// One random request per cycle, responses checked in order
	task automatic test_stream();
		logic [31:0] op_bits;
		logic [31:0] amount;
		logic [31:0] data;
		logic [31:0] expected;
		int unsigned sent;
		int unsigned checked;
		int unsigned idle;
		shift_pkg::shift_op_e op;
		sent = 0;
		checked = 0;
		idle = 0;
		// Let the previous response drop
		next_cycle();
		while (sent < STREAM_LEN || expected_q.size() > 0)
		begin
			if (shift_resp.valid)
			begin
				if (expected_q.size() == 0)
				begin
					fail_run("Shift response arrived with no request outstanding");
				end
				expected = expected_q.pop_front();
				check_value($sformatf("stream response %0d", checked), expected,
					shift_resp.data);
				checked++;
				idle = 0;
			end
			else if (sent == STREAM_LEN)
			begin
				idle++;
				if (idle > TIMEOUT)
				begin
					fail_run("Stream responses stopped arriving");
				end
			end
			if (sent < STREAM_LEN)
			begin
				random_value(3, op_bits);
				// Fold the three unused codes onto valid ones
				if (op_bits > 4)
				begin
					op_bits = op_bits - 3;
				end
				op = shift_pkg::shift_op_e'(op_bits[2:0]);
				random_value(5, amount);
				random_value(32, data);
				expected_q.push_back(expected_shift(op, amount[4:0], data, fill_ones_model));
				drive_shift(op, amount[4:0], data);
				sent++;
			end
			else
			begin
				shift_req.valid = 1'b0;
			end
			next_cycle();
		end
		shift_req.valid = 1'b0;
	endtask

	task automatic test_op_count();
		check_read("operation count", cfg_pkg::CFG_OPS_DONE, issued);
	endtask

	task automatic test_reserved_bits();
		logic [31:0] count;
		write_reg(cfg_pkg::CFG_CTRL, 32'hFFFF_FFFF);
		check_read("reserved bits", cfg_pkg::CFG_CTRL, 32'd1);
		read_reg("count before write", cfg_pkg::CFG_OPS_DONE, count);
		write_reg(cfg_pkg::CFG_OPS_DONE, 32'h0000_1234);
		check_read("count after write", cfg_pkg::CFG_OPS_DONE, count);
		write_reg(cfg_pkg::CFG_CTRL, 32'd0);
	endtask

	// *************************************************
	// Sequence
	// *************************************************

	initial
	begin
		rst = 1'b1;
		shift_req = '0;
		cfg_wr = '0;
		cfg_rd_req = '0;
		lfsr_state = 16'd9217;
		issued = '0;
		fill_ones_model = 1'b0;
		run_ended = 1'b0;
		repeat (10) @(posedge clk);
		#1;
		rst = 1'b0;
		next_cycle();
		test_reset_state();
		test_directed_shifts();
		test_fill_control();
		test_stream();
		test_op_count();
		test_reserved_bits();
		run_ended = 1'b1;
		$display("*** TEST PASSED ***");
		$finish;
	end

	// Run stopped elsewhere, such as by an assertion
	final
	begin
		if (!run_ended)
		begin
			$display("*** TEST FAILED ***");
		end
	end

endmodule

`default_nettype wire

// File: tb.f
common/shift_pkg.sv
common/cfg_pkg.sv
shifter/shift_stage.sv
shifter/barrel_shifter.sv
design/shift_cfg_regs.sv
design/shift_unit_top.sv
bench/tb_clk_gen.sv
bench/shift_unit_chk.sv
bench/shift_unit_tb.sv

// File: Makefile
# Verilator build and run of the shift unit testbench

BUILD_DIR = obj_dir
TOP = shift_unit_tb

.PHONY: compile run clean

compile:
	verilator --binary --timing --assert -Wall -Wno-fatal \
		--top-module $(TOP) -f tb.f --Mdir $(BUILD_DIR) -o $(TOP)

# The log decides pass or fail
run: compile
	./$(BUILD_DIR)/$(TOP) 2>&1 | tee run.log
	grep -qF "*** TEST PASSED ***" run.log

clean:
	rm -rf $(BUILD_DIR) run.log
